// ==== Bender.yml ====
package:
  name: lc3b_pipeline

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - hw/lc3b_types.sv
      - hw/lc3b_pipe_pkg.sv
      - hw/mem_port_if.sv
      - hw/buffer.sv
      - hw/if_datapath.sv
      - hw/id_datapath.sv
      - hw/ex_alu.sv
      - hw/ex_addr_gen.sv
      - hw/mem_datapath.sv
      - hw/cpu_datapath.sv
  - target: test
    include_dirs:
      - include
    files:
      - verif/cpu_datapath_tb.sv

// ==== hw/buffer.sv ====
`timescale 1ns/1ns
`include "lc3b_macros.svh"

module buffer #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     load,
    input  logic     flush,
    input  payload_t d,
    output payload_t q
);

    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            q <= `LC3B_BUBBLE;  // flush wins over load
        end else if (load) begin
            q <= d;
        end
    end

    a_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (!load && !flush) |=> $stable(q));

endmodule : buffer

// ==== hw/cpu_datapath.sv ====
`timescale 1ns/1ns
`include "lc3b_macros.svh"

module cpu_datapath (
    input  logic                    clk,
    input  logic                    rst_n,

    input  logic                    resp_a,
    input  lc3b_types::lc3b_word    rdata_a,
    output logic                    read_a,
    output logic                    write_a,
    output logic [`LC3B_MASK_W-1:0] wmask_a,
    output lc3b_types::lc3b_word    address_a,
    output lc3b_types::lc3b_word    wdata_a,

    input  logic                    resp_b,
    input  lc3b_types::lc3b_word    rdata_b,
    output logic                    read_b,
    output logic                    write_b,
    output logic [`LC3B_MASK_W-1:0] wmask_b,
    output lc3b_types::lc3b_word    address_b,
    output lc3b_types::lc3b_word    wdata_b
);

    mem_port_if port_a ();
    mem_port_if port_b ();

    assign read_a      = port_a.read;
    assign write_a     = port_a.write;
    assign wmask_a     = port_a.wmask;
    assign address_a   = port_a.address;
    assign wdata_a     = port_a.wdata;
    assign port_a.resp = resp_a;
    assign port_a.rdata = rdata_a;

    assign read_b      = port_b.read;
    assign write_b     = port_b.write;
    assign wmask_b     = port_b.wmask;
    assign address_b   = port_b.address;
    assign wdata_b     = port_b.wdata;
    assign port_b.resp = resp_b;
    assign port_b.rdata = rdata_b;

    logic                   stall, fetch_busy, mem_busy, fetch_valid, hazard, redirect;
    lc3b_types::lc3b_word   br_target, alu_result, eff_addr, ex_br_target;
    lc3b_types::lc3b_nzp    cc;
    logic                   br_en;
    lc3b_pipe_pkg::if_id_t  if_d, if_id_q;
    lc3b_pipe_pkg::id_ex_t  id_d, id_ex_q;
    lc3b_pipe_pkg::ex_mem_t ex_d, ex_mem_q;
    lc3b_pipe_pkg::mem_wb_t mem_d, mem_wb_q;

    assign stall = fetch_busy || mem_busy;

    // ----------------------------------------
    // fetch and decode
    // ----------------------------------------
    if_datapath u_if (.clk(clk), .rst_n(rst_n), .hold(stall || hazard), .redirect(redirect),
        .br_target(br_target), .mem(port_a.master), .fetch_busy(fetch_busy),
        .fetched(if_d), .fetch_valid(fetch_valid));

    buffer #(.payload_t(lc3b_pipe_pkg::if_id_t)) if_id_buf (.clk(clk), .rst_n(rst_n),
        .load(fetch_valid && !stall && !hazard), .flush(redirect), .d(if_d), .q(if_id_q));

    id_datapath u_id (.clk(clk), .rst_n(rst_n), .stall(stall), .in(if_id_q), .wb(mem_wb_q),
        .ex_dest_info(id_ex_q), .mem_dest_info(ex_mem_q), .out(id_d), .hazard(hazard),
        .cc(cc));

    buffer #(.payload_t(lc3b_pipe_pkg::id_ex_t)) id_ex_buf (.clk(clk), .rst_n(rst_n),
        .load(!stall), .flush(hazard || redirect), .d(id_d), .q(id_ex_q));

    // ----------------------------------------
    // execute, memory
    // ----------------------------------------
    ex_alu u_alu (.in(id_ex_q), .alu_result(alu_result));

    ex_addr_gen u_addr (.in(id_ex_q), .cc(cc), .eff_addr(eff_addr),
        .br_target(ex_br_target), .br_en(br_en));

    always_comb begin
        ex_d.ctrl       = id_ex_q.ctrl;
        ex_d.dest       = id_ex_q.dest;
        ex_d.alu_result = alu_result;
        ex_d.eff_addr   = eff_addr;
        ex_d.br_target  = ex_br_target;
        ex_d.store_data = id_ex_q.src2_data;
        ex_d.br_en      = br_en;
    end

    buffer #(.payload_t(lc3b_pipe_pkg::ex_mem_t)) ex_mem_buf (.clk(clk), .rst_n(rst_n),
        .load(!stall), .flush(redirect), .d(ex_d), .q(ex_mem_q));

    mem_datapath u_mem (.clk(clk), .rst_n(rst_n), .stall(stall), .in(ex_mem_q),
        .mem(port_b.master), .mem_busy(mem_busy), .redirect(redirect),
        .br_target(br_target), .out(mem_d));

    // writeback is the mem_wb output feeding the register file
    buffer #(.payload_t(lc3b_pipe_pkg::mem_wb_t)) mem_wb_buf (.clk(clk), .rst_n(rst_n),
        .load(!stall), .flush(1'b0), .d(mem_d), .q(mem_wb_q));

endmodule : cpu_datapath

// ==== hw/ex_addr_gen.sv ====
`timescale 1ns/1ns

module ex_addr_gen (
    input  lc3b_pipe_pkg::id_ex_t in,
    input  lc3b_types::lc3b_nzp   cc,
    output lc3b_types::lc3b_word  eff_addr,
    output lc3b_types::lc3b_word  br_target,
    output logic                  br_en
);

    lc3b_types::lc3b_word offset6;
    lc3b_types::lc3b_word offset9;

    // word offsets, scaled to bytes
    assign offset6 = {{9{in.instr[5]}}, in.instr[5:0], 1'b0};
    assign offset9 = {{6{in.instr[8]}}, in.instr[8:0], 1'b0};

    assign eff_addr  = in.src1_data + offset6;
    assign br_target = in.pc + offset9;
    assign br_en     = in.ctrl.branch && |(in.instr[11:9] & cc);

endmodule : ex_addr_gen

// ==== hw/ex_alu.sv ====
`timescale 1ns/1ns

module ex_alu (
    input  lc3b_pipe_pkg::id_ex_t in,
    output lc3b_types::lc3b_word  alu_result
);

    lc3b_types::lc3b_word imm5;
    lc3b_types::lc3b_word b;

    assign imm5 = {{11{in.instr[4]}}, in.instr[4:0]};
    assign b    = in.ctrl.imm_sel ? imm5 : in.src2_data;

    always_comb begin
        case (in.ctrl.alu_op)
            lc3b_pipe_pkg::alu_and: alu_result = in.src1_data & b;
            lc3b_pipe_pkg::alu_not: alu_result = ~in.src1_data;
            default:                alu_result = in.src1_data + b;
        endcase
    end

endmodule : ex_alu

// ==== hw/id_datapath.sv ====
`timescale 1ns/1ns

module id_datapath (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   stall,
    input  lc3b_pipe_pkg::if_id_t  in,
    input  lc3b_pipe_pkg::mem_wb_t wb,
    input  lc3b_pipe_pkg::id_ex_t  ex_dest_info,
    input  lc3b_pipe_pkg::ex_mem_t mem_dest_info,
    output lc3b_pipe_pkg::id_ex_t  out,
    output logic                   hazard,
    output lc3b_types::lc3b_nzp    cc
);

    lc3b_types::lc3b_word             regs [8];
    lc3b_pipe_pkg::lc3b_control_word  ctrl;
    lc3b_types::lc3b_reg              sr1;
    lc3b_types::lc3b_reg              sr2;
    logic                             use_sr1;
    logic                             use_sr2;
    logic                             sr1_hit;
    logic                             sr2_hit;
    logic                             cc_busy;

    // ----------------------------------------
    // decode
    // ----------------------------------------
    always_comb begin
        ctrl = '0;
        case (lc3b_types::lc3b_opcode'(in.instr[15:12]))
            lc3b_types::op_add, lc3b_types::op_and, lc3b_types::op_not: begin
                ctrl.opcode    = lc3b_types::lc3b_opcode'(in.instr[15:12]);
                ctrl.alu_op    = (in.instr[15:12] == lc3b_types::op_add) ? lc3b_pipe_pkg::alu_add :
                                 (in.instr[15:12] == lc3b_types::op_and) ? lc3b_pipe_pkg::alu_and :
                                                                           lc3b_pipe_pkg::alu_not;
                ctrl.imm_sel   = in.instr[5];
                ctrl.reg_write = 1'b1;
                ctrl.cc_set    = 1'b1;
            end
            lc3b_types::op_ldr: begin
                ctrl.opcode    = lc3b_types::op_ldr;
                ctrl.reg_write = 1'b1;
                ctrl.cc_set    = 1'b1;
                ctrl.mem_read  = 1'b1;
            end
            lc3b_types::op_str: begin
                ctrl.opcode    = lc3b_types::op_str;
                ctrl.mem_write = 1'b1;
            end
            lc3b_types::op_br: begin
                ctrl.branch = |in.instr[11:9];  // nzp of 000 is a nop
            end
            default: ;
        endcase
    end

    assign sr1     = in.instr[8:6];
    assign sr2     = ctrl.mem_write ? in.instr[11:9] : in.instr[2:0];
    assign use_sr1 = ctrl.reg_write || ctrl.mem_write;
    assign use_sr2 = ctrl.mem_write || (ctrl.reg_write && !ctrl.imm_sel && !ctrl.mem_read &&
                     ctrl.alu_op != lc3b_pipe_pkg::alu_not);

    // ----------------------------------------
    // hazards
    // ----------------------------------------
    // a write waiting in mem_wb reaches decode through write-through
    assign sr1_hit = (ex_dest_info.ctrl.reg_write && ex_dest_info.dest == sr1) ||
                     (mem_dest_info.ctrl.reg_write && mem_dest_info.dest == sr1);
    assign sr2_hit = (ex_dest_info.ctrl.reg_write && ex_dest_info.dest == sr2) ||
                     (mem_dest_info.ctrl.reg_write && mem_dest_info.dest == sr2);
    assign cc_busy = ex_dest_info.ctrl.cc_set || mem_dest_info.ctrl.cc_set || wb.ctrl.cc_set;

    // frozen pipeline already holds decode
    assign hazard = !stall && ((use_sr1 && sr1_hit) || (use_sr2 && sr2_hit) ||
                    (ctrl.branch && cc_busy));

    // ----------------------------------------
    // register file and cc
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            regs <= '{default: '0};
            cc   <= 3'b010;
        end else begin
            if (wb.ctrl.reg_write) begin
                regs[wb.dest] <= wb.dest_data;
            end
            if (wb.ctrl.cc_set) begin
                cc <= {wb.dest_data[15], wb.dest_data == '0,
                       !wb.dest_data[15] && wb.dest_data != '0};
            end
        end
    end

    always_comb begin
        out.ctrl      = ctrl;
        out.pc        = in.pc;
        out.instr     = in.instr;
        out.dest      = in.instr[11:9];
        // write-through from writeback
        out.src1_data = (wb.ctrl.reg_write && wb.dest == sr1) ? wb.dest_data : regs[sr1];
        out.src2_data = (wb.ctrl.reg_write && wb.dest == sr2) ? wb.dest_data : regs[sr2];
    end

    a_wb_legal: assert property (@(posedge clk) disable iff (!rst_n)
        wb.ctrl.reg_write |-> wb.ctrl.opcode inside {lc3b_types::op_add, lc3b_types::op_and,
                                                      lc3b_types::op_not, lc3b_types::op_ldr});

endmodule : id_datapath

// ==== hw/if_datapath.sv ====
`timescale 1ns/1ns
`include "lc3b_macros.svh"

module if_datapath (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  hold,
    input  logic                  redirect,
    input  lc3b_types::lc3b_word  br_target,
    mem_port_if.master            mem,
    output logic                  fetch_busy,
    output lc3b_pipe_pkg::if_id_t fetched,
    output logic                  fetch_valid
);

    lc3b_types::lc3b_word pc;
    lc3b_types::lc3b_word inst_q;     // instruction parked while decode is held
    lc3b_types::lc3b_word target_q;
    logic                 reading;
    logic                 have_q;
    logic                 redir_q;    // redirect seen while a read was in flight
    logic                 consume;

    assign mem.read    = reading;
    assign mem.write   = 1'b0;
    assign mem.wmask   = '0;
    assign mem.wdata   = '0;
    assign mem.address = pc;

    assign fetch_valid = (have_q || (reading && mem.resp)) && !redir_q;
    assign fetch_busy  = !fetch_valid;
    assign consume     = fetch_valid && !hold;

    always_comb begin
        fetched = `LC3B_BUBBLE;
        if (fetch_valid) begin
            fetched.pc    = pc + 16'd2;
            fetched.instr = have_q ? inst_q : mem.rdata;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc      <= `LC3B_RESET_PC;
            reading <= 1'b0;
            have_q  <= 1'b0;
            redir_q <= 1'b0;
        end else if (redirect && reading && !mem.resp) begin
            redir_q <= 1'b1;  // let the old read finish first
        end else if (redirect) begin
            pc      <= br_target;
            have_q  <= 1'b0;
            reading <= 1'b1;
        end else if (reading && mem.resp && redir_q) begin
            pc      <= target_q;  // stale word dropped, new request next cycle
            redir_q <= 1'b0;
        end else if (consume) begin
            pc      <= pc + 16'd2;
            have_q  <= 1'b0;
            reading <= 1'b1;
        end else if (reading && mem.resp) begin
            have_q  <= 1'b1;
            reading <= 1'b0;
        end else if (!reading && !have_q) begin
            reading <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reading && mem.resp) begin
            inst_q <= mem.rdata;
        end
        if (redirect) begin
            target_q <= br_target;
        end
    end

    a_addr_stable: assert property (@(posedge clk) disable iff (!rst_n)
        (mem.read && !mem.resp) |=> $stable(mem.address));

endmodule : if_datapath

// ==== hw/lc3b_pipe_pkg.sv ====
package lc3b_pipe_pkg;

    typedef enum logic [1:0] {
        alu_add = 2'b00,
        alu_and = 2'b01,
        alu_not = 2'b10
    } lc3b_alu_op;

    // all zero means bubble
    typedef struct packed {
        lc3b_types::lc3b_opcode opcode;
        lc3b_alu_op             alu_op;
        logic                   imm_sel;
        logic                   reg_write;
        logic                   cc_set;
        logic                   mem_read;
        logic                   mem_write;
        logic                   branch;
    } lc3b_control_word;

    typedef struct packed {
        lc3b_types::lc3b_word pc;  // already incremented
        lc3b_types::lc3b_word instr;
    } if_id_t;

    typedef struct packed {
        lc3b_control_word     ctrl;
        lc3b_types::lc3b_word pc;
        lc3b_types::lc3b_word instr;
        lc3b_types::lc3b_reg  dest;
        lc3b_types::lc3b_word src1_data;
        lc3b_types::lc3b_word src2_data;
    } id_ex_t;

    typedef struct packed {
        lc3b_control_word     ctrl;
        lc3b_types::lc3b_reg  dest;
        lc3b_types::lc3b_word alu_result;
        lc3b_types::lc3b_word eff_addr;
        lc3b_types::lc3b_word br_target;
        lc3b_types::lc3b_word store_data;
        logic                 br_en;
    } ex_mem_t;

    typedef struct packed {
        lc3b_control_word     ctrl;
        lc3b_types::lc3b_reg  dest;
        lc3b_types::lc3b_word dest_data;
    } mem_wb_t;

endpackage : lc3b_pipe_pkg

// ==== hw/lc3b_types.sv ====
`include "lc3b_macros.svh"

package lc3b_types;

    typedef logic [`LC3B_WORD_W-1:0] lc3b_word;
    typedef logic [2:0] lc3b_reg;
    typedef logic [2:0] lc3b_nzp;  // n, z, p

    // only the opcodes this core executes
    typedef enum logic [3:0] {
        op_br  = 4'b0000,
        op_add = 4'b0001,
        op_and = 4'b0101,
        op_ldr = 4'b0110,
        op_str = 4'b0111,
        op_not = 4'b1001
    } lc3b_opcode;

endpackage : lc3b_types

// ==== hw/mem_datapath.sv ====
`timescale 1ns/1ns

module mem_datapath (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   stall,
    input  lc3b_pipe_pkg::ex_mem_t in,
    mem_port_if.master             mem,
    output logic                   mem_busy,
    output logic                   redirect,
    output lc3b_types::lc3b_word   br_target,
    output lc3b_pipe_pkg::mem_wb_t out
);

    logic                 access;
    logic                 done_q;   // access finished, waiting for the pipe to move
    lc3b_types::lc3b_word ld_q;
    lc3b_types::lc3b_word ld_data;

    assign access = in.ctrl.mem_read || in.ctrl.mem_write;

    assign mem.read    = in.ctrl.mem_read && !done_q;
    assign mem.write   = in.ctrl.mem_write && !done_q;
    assign mem.wmask   = '1;
    assign mem.address = in.eff_addr;
    assign mem.wdata   = in.store_data;

    assign mem_busy = access && !done_q && !mem.resp;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            done_q <= 1'b0;
        end else begin
            done_q <= stall && (done_q || mem.resp);
        end
    end

    always_ff @(posedge clk) begin
        if (mem.resp) begin
            ld_q <= mem.rdata;
        end
    end

    assign ld_data = done_q ? ld_q : mem.rdata;

    assign redirect  = in.br_en;
    assign br_target = in.br_target;

    always_comb begin
        out.ctrl      = in.ctrl;
        out.dest      = in.dest;
        out.dest_data = in.ctrl.mem_read ? ld_data : in.alu_result;
    end

    a_one_strobe: assert property (@(posedge clk) disable iff (!rst_n)
        !(mem.read && mem.write));

endmodule : mem_datapath

// ==== hw/mem_port_if.sv ====
`timescale 1ns/1ns
`include "lc3b_macros.svh"

interface mem_port_if;

    logic                    read;
    logic                    write;
    logic [`LC3B_MASK_W-1:0] wmask;
    logic [`LC3B_WORD_W-1:0] address;
    logic [`LC3B_WORD_W-1:0] wdata;
    logic                    resp;   // one-cycle completion pulse
    logic [`LC3B_WORD_W-1:0] rdata;  // valid with resp

    modport master (output read, write, wmask, address, wdata, input resp, rdata);
    modport slave (input read, write, wmask, address, wdata, output resp, rdata);

endinterface : mem_port_if

// ==== include/lc3b_macros.svh ====
`ifndef LC3B_MACROS_SVH
`define LC3B_MACROS_SVH

// ----------------------------------------
// core-wide constants
// ----------------------------------------

// first fetch address after reset
`define LC3B_RESET_PC 16'h0000

// memory port widths
`define LC3B_WORD_W 16
`define LC3B_MASK_W 2

// value a pipeline register holds after reset or flush
`define LC3B_BUBBLE '0

`endif

// ==== verif/cpu_datapath_tb.sv ====
`timescale 1ns/1ns
`include "lc3b_macros.svh"

module cpu_datapath_tb;

    localparam int rom_words   = 64;
    localparam int prog_len    = 33;
    localparam int cycle_limit = prog_len * 4 * 8 + 100;

    logic                    clk = 1'b0;
    logic                    rst_n;
    logic                    resp_a = 1'b0;
    logic [15:0]             rdata_a = '0;
    logic                    resp_b = 1'b0;
    logic [15:0]             rdata_b = '0;
    logic                    read_a, write_a, read_b, write_b;
    logic [`LC3B_MASK_W-1:0] wmask_a, wmask_b;
    logic [15:0]             address_a, wdata_a, address_b, wdata_b;

    logic [15:0] rom [rom_words];
    logic [15:0] ram [256];
    logic [15:0] exp_addr [$];
    logic [15:0] exp_data [$];
    logic        a_busy, b_busy;
    logic [1:0]  a_cnt, b_cnt;
    integer      seed = 32'h5bc;
    int          cycles = 0;
    int          store_cnt = 0;
    int          errors = 0;
    int          grp_err [5] = '{default: 0};

    cpu_datapath UUT (
        .clk(clk), .rst_n(rst_n),
        .resp_a(resp_a), .rdata_a(rdata_a), .read_a(read_a), .write_a(write_a),
        .wmask_a(wmask_a), .address_a(address_a), .wdata_a(wdata_a),
        .resp_b(resp_b), .rdata_b(rdata_b), .read_b(read_b), .write_b(write_b),
        .wmask_b(wmask_b), .address_b(address_b), .wdata_b(wdata_b)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        if (rst_n) cycles <= cycles + 1;
    end

    // ----------------------------------------
    // instruction encoding and memory contents
    // ----------------------------------------
    function automatic logic [15:0] alu_reg(input logic [3:0] op, input int dr, sr1, sr2);
        return {op, dr[2:0], sr1[2:0], 3'b000, sr2[2:0]};
    endfunction

    function automatic logic [15:0] alu_imm(input logic [3:0] op, input int dr, sr1, imm);
        return {op, dr[2:0], sr1[2:0], 1'b1, imm[4:0]};
    endfunction

    function automatic logic [15:0] not_reg(input int dr, sr);
        return {4'b1001, dr[2:0], sr[2:0], 6'b111111};
    endfunction

    function automatic logic [15:0] mem_op(input logic [3:0] op, input int r, base, off);
        return {op, r[2:0], base[2:0], off[5:0]};
    endfunction

    function automatic logic [15:0] branch(input int nzp, off);
        return {4'b0000, nzp[2:0], off[8:0]};
    endfunction

    function automatic logic [15:0] fill_word(input int i);
        return {i[7:0] ^ 8'ha5, i[7:0] + 8'h3c};
    endfunction

    function automatic logic [15:0] rom_word(input logic [15:0] addr);
        logic [15:0] off;
        off = addr - `LC3B_RESET_PC;
        if (off[15:1] < rom_words) return rom[off[15:1]];
        return 16'h0000;  // BR with nzp 000, a nop
    endfunction

    // stores land at 0x20.. for alu, 0x30.. for load-use, 0x38.. for branches
    task automatic load_program();
        for (int i = 0; i < rom_words; i++) rom[i] = 16'h0000;
        rom[0]  = alu_imm(lc3b_types::op_and, 6, 6, 0);   // r6 = base 0
        rom[1]  = alu_imm(lc3b_types::op_and, 0, 0, 0);
        rom[2]  = alu_imm(lc3b_types::op_add, 0, 0, 13);
        rom[3]  = alu_imm(lc3b_types::op_add, 1, 0, -7);
        rom[4]  = alu_reg(lc3b_types::op_add, 2, 0, 1);
        rom[5]  = alu_imm(lc3b_types::op_and, 3, 2, -3);
        rom[6]  = alu_reg(lc3b_types::op_and, 4, 2, 0);
        rom[7]  = not_reg(5, 2);
        rom[8]  = mem_op(lc3b_types::op_str, 2, 6, 16);
        rom[9]  = mem_op(lc3b_types::op_str, 3, 6, 17);
        rom[10] = mem_op(lc3b_types::op_str, 4, 6, 18);
        rom[11] = mem_op(lc3b_types::op_str, 5, 6, 19);
        rom[12] = alu_imm(lc3b_types::op_add, 1, 1, -15);
        rom[13] = mem_op(lc3b_types::op_str, 1, 6, 20);
        rom[14] = mem_op(lc3b_types::op_ldr, 0, 6, 1);    // load then use at once
        rom[15] = alu_imm(lc3b_types::op_add, 1, 0, 3);
        rom[16] = mem_op(lc3b_types::op_str, 1, 6, 24);
        rom[17] = mem_op(lc3b_types::op_ldr, 2, 6, 2);
        rom[18] = not_reg(3, 2);
        rom[19] = mem_op(lc3b_types::op_str, 3, 6, 25);
        rom[20] = alu_reg(lc3b_types::op_and, 4, 3, 0);
        rom[21] = mem_op(lc3b_types::op_str, 4, 6, 26);
        rom[22] = alu_imm(lc3b_types::op_and, 0, 0, 0);
        rom[23] = branch(3'b010, 2);                      // taken
        rom[24] = mem_op(lc3b_types::op_str, 2, 6, 28);
        rom[25] = mem_op(lc3b_types::op_str, 3, 6, 29);
        rom[26] = alu_imm(lc3b_types::op_add, 1, 0, 5);
        rom[27] = branch(3'b100, 1);                      // not taken
        rom[28] = mem_op(lc3b_types::op_str, 1, 6, 30);
        rom[29] = branch(3'b001, 1);
        rom[30] = mem_op(lc3b_types::op_str, 0, 6, 28);
        rom[31] = mem_op(lc3b_types::op_str, 1, 6, 31);
        rom[32] = branch(3'b111, -1);                     // branch to self
        for (int i = 0; i < 256; i++) ram[i] = fill_word(i);
    endtask

    // ISA model, fills the ordered list of expected stores
    function automatic void run_reference();
        logic [15:0] r [8];
        logic [15:0] mem [256];
        logic [15:0] pc, ins, next_pc, b, addr, res;
        logic [2:0]  cc;
        logic        wr;
        for (int i = 0; i < 8; i++) r[i] = '0;
        for (int i = 0; i < 256; i++) mem[i] = fill_word(i);
        pc = `LC3B_RESET_PC;
        cc = 3'b010;
        for (int step = 0; step < 1000; step++) begin
            ins     = rom_word(pc);
            next_pc = pc + 16'd2;
            wr      = 1'b0;
            res     = '0;
            addr    = r[ins[8:6]] + {{9{ins[5]}}, ins[5:0], 1'b0};
            b       = ins[5] ? {{11{ins[4]}}, ins[4:0]} : r[ins[2:0]];
            case (ins[15:12])
                lc3b_types::op_add: begin
                    res = r[ins[8:6]] + b;
                    wr  = 1'b1;
                end
                lc3b_types::op_and: begin
                    res = r[ins[8:6]] & b;
                    wr  = 1'b1;
                end
                lc3b_types::op_not: begin
                    res = ~r[ins[8:6]];
                    wr  = 1'b1;
                end
                lc3b_types::op_ldr: begin
                    res = mem[addr[8:1]];
                    wr  = 1'b1;
                end
                lc3b_types::op_str: begin
                    mem[addr[8:1]] = r[ins[11:9]];
                    exp_addr.push_back(addr);
                    exp_data.push_back(r[ins[11:9]]);
                end
                lc3b_types::op_br: begin
                    if (|(ins[11:9] & cc)) next_pc = next_pc + {{6{ins[8]}}, ins[8:0], 1'b0};
                end
                default: ;
            endcase
            if (wr) begin
                r[ins[11:9]] = res;
                cc = {res[15], res == 16'h0, !res[15] && res != 16'h0};
            end
            if (next_pc == pc) break;
            pc = next_pc;
        end
    endfunction

    // ----------------------------------------
    // memory models, 0 to 3 cycles of delay
    // ----------------------------------------
    always @(posedge clk) begin
        logic [1:0] dly;
        if (!rst_n) begin
            resp_a <= 1'b0;
            resp_b <= 1'b0;
            a_busy <= 1'b0;
            b_busy <= 1'b0;
        end else begin
            resp_a <= 1'b0;
            resp_b <= 1'b0;
            if (a_busy) begin
                if (a_cnt == 0) begin
                    resp_a  <= 1'b1;
                    rdata_a <= rom_word(address_a);
                    a_busy  <= 1'b0;
                end else a_cnt <= a_cnt - 1;
            end else if (read_a && !resp_a) begin  // a strobe seen with resp is the old one
                dly = $random(seed);
                a_busy <= 1'b1;
                a_cnt  <= dly;
            end
            if (b_busy) begin
                if (b_cnt == 0) begin
                    resp_b <= 1'b1;
                    if (write_b) ram[address_b[8:1]] <= wdata_b;
                    else rdata_b <= ram[address_b[8:1]];
                    b_busy <= 1'b0;
                end else b_cnt <= b_cnt - 1;
            end else if ((read_b || write_b) && !resp_b) begin
                dly = $random(seed);
                b_busy <= 1'b1;
                b_cnt  <= dly;
            end
        end
    end

    // ----------------------------------------
    // checking
    // ----------------------------------------
    task automatic count_error(input int g);
        errors++;
        grp_err[g]++;
    endtask

    task automatic check(input string name, input logic [15:0] got, input logic [15:0] exp,
                         input int g);
        if (got !== exp) begin
            $display("Mismatch %s: got %h, expected %h", name, got, exp);
            count_error(g);
        end
    endtask

    function automatic int group_of(input logic [15:0] addr);
        if (addr < 16'h0030) return 1;
        if (addr < 16'h0038) return 2;
        return 3;
    endfunction

    always @(negedge clk) begin
        if (rst_n) begin
            // port A only ever reads
            check("write_a", write_a, 16'h0, 4);
            check("wmask_a", wmask_a, 16'h0, 4);
            check("wdata_a", wdata_a, 16'h0, 4);
        end
        if (rst_n && read_b && write_b) begin
            $display("read_b and write_b are high together at %0t ns", $time);
            count_error(4);
        end
        if (rst_n && resp_b && write_b) begin
            if (store_cnt < exp_addr.size()) begin
                check("address_b", address_b, exp_addr[store_cnt], group_of(exp_addr[store_cnt]));
                check("wdata_b", wdata_b, exp_data[store_cnt], group_of(exp_addr[store_cnt]));
                check("wmask_b", wmask_b, {`LC3B_MASK_W{1'b1}}, group_of(exp_addr[store_cnt]));
            end else begin
                $display("extra store to %h with data %h", address_b, wdata_b);
                count_error(4);
            end
            store_cnt++;
        end
    end

    int passed = 0;
    int failed = 0;

    task automatic report_test(input string name, input int g);
        if (grp_err[g] == 0) begin
            $display("test %-10s ok", name);
            passed++;
        end else begin
            $display("test %-10s %0d error(s)", name, grp_err[g]);
            failed++;
        end
    endtask

    initial begin
        int n;
        rst_n = 1'b0;
        load_program();
        run_reference();
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;

        @(negedge clk);
        check("read_b", read_b, 16'h0, 0);
        check("write_b", write_b, 16'h0, 0);
        n = 0;
        while (!read_a && n < 8) begin
            @(negedge clk);
            n++;
        end
        if (!read_a) begin
            $display("read_a never rose after reset");
            count_error(0);
        end else check("address_a", address_a, `LC3B_RESET_PC, 0);
        report_test("reset", 0);

        while (store_cnt < exp_addr.size() && cycles < cycle_limit) @(posedge clk);
        if (store_cnt < exp_addr.size()) begin
            $display("timeout after %0d cycles, the core stopped making stores (%0d of %0d)",
                     cycles, store_cnt, exp_addr.size());
            $display("tests failed");
            $finish;
        end else begin
            repeat (60) @(posedge clk);  // a store from a flushed path would show up here
            check("store count", store_cnt, exp_addr.size(), 4);
            report_test("alu", 1);
            report_test("load_use", 2);
            report_test("branch", 3);
            report_test("stream", 4);
            $display("%0d tests, %0d ok, %0d not ok, %0d errors", passed + failed, passed,
                     failed, errors);
            if (errors == 0) begin
                $display("all tests passed");
            end else begin
                $display("tests failed");
            end
            $finish;
        end
    end

endmodule : cpu_datapath_tb

// ==== verilog.f ====
+incdir+include
hw/lc3b_types.sv
hw/lc3b_pipe_pkg.sv
hw/mem_port_if.sv
hw/buffer.sv
hw/if_datapath.sv
hw/id_datapath.sv
hw/ex_alu.sv
hw/ex_addr_gen.sv
hw/mem_datapath.sv
hw/cpu_datapath.sv
verif/cpu_datapath_tb.sv
